//--- bench/mipsRefModel.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// Architectural state, updated in program order
logic [31:0] refRegs [32];
logic [31:0] refMem [256];

// Registers start at zero after reset
// Memory is cleared here only; the bench stores every word it loads from first
function automatic void resetRefModel();
   refRegs = '{default: 32'h0};
   refMem = '{default: 32'h0};
endfunction

// Runs one instruction on the reference state
// Returns 1 when the instruction writes a register, r0 included
function automatic logic refExecute(
   input  logic [31:0] ins,
   output logic [4:0]  dest,
   output logic [31:0] value
);
   logic [5:0]  op;
   logic [5:0]  fn;
   logic [4:0]  sh;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] simm;
   logic [31:0] zimm;
   logic [31:0] addr;
   logic [31:0] word;
   logic [31:0] lane;
   logic [7:0]  index;
   logic        writes;
   op = ins[31:26];
   fn = ins[5:0];
   sh = ins[10:6];
   a = refRegs[ins[25:21]];
   b = refRegs[ins[20:16]];
   simm = {{16{ins[15]}}, ins[15:0]};
   zimm = {16'h0, ins[15:0]};
   // Byte address and word index
   addr = a + simm;
   index = addr[9:2];
   word = refMem[index];
   // Addressed byte or halfword moved down to bit 0
   lane = word >> {addr[1:0], 3'b000};
   writes = 1'b1;
   dest = ins[20:16];
   value = 32'h0;
   case (op)
      6'h00: begin
         dest = ins[15:11];
         case (fn)
            6'h00: value = b << sh;
            6'h02: value = b >> sh;
            6'h03: value = $signed(b) >>> sh;
            // No overflow traps modelled
            6'h20, 6'h21: value = a + b;
            6'h22, 6'h23: value = a - b;
            6'h24: value = a & b;
            6'h25: value = a | b;
            6'h26: value = a ^ b;
            6'h27: value = ~(a | b);
            6'h2a: value = {31'h0, $signed(a) < $signed(b)};
            6'h2b: value = {31'h0, a < b};
            default: writes = 1'b0;
         endcase
      end
      6'h08, 6'h09: value = a + simm;
      6'h0a: value = {31'h0, $signed(a) < $signed(simm)};
      6'h0b: value = {31'h0, a < simm};
      // Logical immediates zero extended
      6'h0c: value = a & zimm;
      6'h0d: value = a | zimm;
      6'h0e: value = a ^ zimm;
      6'h0f: value = {ins[15:0], 16'h0};
      // lb, lh, lw, lbu, lhu
      6'h20: value = {{24{lane[7]}}, lane[7:0]};
      6'h21: value = {{16{lane[15]}}, lane[15:0]};
      6'h23: value = word;
      6'h24: value = {24'h0, lane[7:0]};
      6'h25: value = {16'h0, lane[15:0]};
      // Stores change only the addressed bytes
      6'h28: begin
         writes = 1'b0;
         refMem[index][{addr[1:0], 3'b000} +: 8] = b[7:0];
      end
      6'h29: begin
         writes = 1'b0;
         refMem[index][{addr[1], 4'b0000} +: 16] = b[15:0];
      end
      6'h2b: begin
         writes = 1'b0;
         refMem[index] = b;
      end
      default: writes = 1'b0;
   endcase
   // r0 stays zero
   if (writes && dest != 5'd0) begin
      refRegs[dest] = value;
   end
   return writes;
endfunction

`endif

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

   logic                             clk;
   logic                             reset;
   logic                             instrValid;
   logic [31:0]                      instr;
   logic                             wbValid;
   logic [mipsPkg::RegAddrWidth-1:0] wbAddr;
   logic [mipsPkg::DataWidth-1:0]    wbData;

   int         seed = 32'hafb4;
   logic [4:0] lastDest = 5'd0;
   logic       gapsAllowed = 1'b1;

   // Expected writebacks, oldest first
   logic [mipsPkg::RegAddrWidth-1:0] expAddr [$];
   logic [mipsPkg::DataWidth-1:0]    expData [$];

   `include "mipsRefModel.svh"

   mipsCore mipsCore_i (
      .clk        (clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .wbValid    (wbValid),
      .wbAddr     (wbAddr),
      .wbData     (wbData)
   );

   // 100 ns period
   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic logic [31:0] nextRand();
      return $random(seed);
   endfunction

   function automatic logic [4:0] randReg();
      logic [31:0] r;
      r = nextRand();
      return r[4:0];
   endfunction

   function automatic logic [31:0] encodeR(
      input logic [5:0] fn,
      input logic [4:0] rs,
      input logic [4:0] rt,
      input logic [4:0] rd,
      input logic [4:0] sh
   );
      return {mipsPkg::OpRType, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] encodeI(
      input logic [5:0]  op,
      input logic [4:0]  rs,
      input logic [4:0]  rt,
      input logic [15:0] imm
   );
      return {op, rs, rt, imm};
   endfunction

   // The 13 R-type functions with upper codes repeating sltu
   function automatic logic [5:0] functAt(input logic [3:0] k);
      case (k)
         4'd0:  return mipsPkg::FnSll;
         4'd1:  return mipsPkg::FnSrl;
         4'd2:  return mipsPkg::FnSra;
         4'd3:  return mipsPkg::FnAdd;
         4'd4:  return mipsPkg::FnAddu;
         4'd5:  return mipsPkg::FnSub;
         4'd6:  return mipsPkg::FnSubu;
         4'd7:  return mipsPkg::FnAnd;
         4'd8:  return mipsPkg::FnOr;
         4'd9:  return mipsPkg::FnXor;
         4'd10: return mipsPkg::FnNor;
         4'd11: return mipsPkg::FnSlt;
         default: return mipsPkg::FnSltu;
      endcase
   endfunction

   function automatic logic [5:0] immOpAt(input logic [2:0] k);
      case (k)
         3'd0:    return mipsPkg::OpAddi;
         3'd1:    return mipsPkg::OpAddiu;
         3'd2:    return mipsPkg::OpSlti;
         3'd3:    return mipsPkg::OpSltiu;
         3'd4:    return mipsPkg::OpAndi;
         3'd5:    return mipsPkg::OpOri;
         3'd6:    return mipsPkg::OpXori;
         default: return mipsPkg::OpLui;
      endcase
   endfunction

   function automatic logic [5:0] memOpAt(input logic [2:0] k);
      case (k)
         3'd0:    return mipsPkg::OpLb;
         3'd1:    return mipsPkg::OpLh;
         3'd2:    return mipsPkg::OpLw;
         3'd3:    return mipsPkg::OpLbu;
         3'd4:    return mipsPkg::OpLhu;
         3'd5:    return mipsPkg::OpSb;
         3'd6:    return mipsPkg::OpSh;
         default: return mipsPkg::OpSw;
      endcase
   endfunction

   // Random ALU, load or store op that half the time reads the newest result
   function automatic logic [31:0] randomInstr();
      logic [31:0] r;
      logic [31:0] ins;
      logic [4:0]  src;
      logic [5:0]  op;
      logic [15:0] off;
      r = nextRand();
      src = r[2] ? lastDest : randReg();
      case (r[1:0])
         2'd0: ins = encodeR(functAt(r[7:4]), src, randReg(), randReg(), randReg());
         2'd1: ins = encodeI(immOpAt(r[10:8]), src, randReg(), r[31:16]);
         default: begin
            op = memOpAt(r[10:8]);
            // Base r0 keeps the address inside the filled 64-byte window
            off = {10'h0, r[16:11]};
            if (op[1:0] == 2'b11) begin
               off[1:0] = 2'b00;
            end else if (op[1:0] == 2'b01) begin
               off[0] = 1'b0;
            end
            // Stores have opcode bit 3 set and take src as data
            ins = encodeI(op, 5'd0, op[3] ? src : randReg(), off);
         end
      endcase
      return ins;
   endfunction

   task automatic abortRun();
      $display("Simulation failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic compareAddr(
      input logic [mipsPkg::RegAddrWidth-1:0] got,
      input logic [mipsPkg::RegAddrWidth-1:0] exp
   );
      if (got !== exp) begin
         $display("Fail wbAddr: got 0x%h expected 0x%h", got, exp);
         abortRun();
      end
   endtask

   task automatic compareData(
      input logic [mipsPkg::DataWidth-1:0] got,
      input logic [mipsPkg::DataWidth-1:0] exp
   );
      if (got !== exp) begin
         $display("Fail wbData: got 0x%h expected 0x%h", got, exp);
         abortRun();
      end
   endtask

   // Optional random bubbles before one valid instruction run through the reference
   task automatic issue(input logic [31:0] ins);
      logic [4:0]  dest;
      logic [31:0] value;
      logic [31:0] r;
      r = nextRand();
      for (int n = 0; n < 3 && gapsAllowed && r[1:0] == 2'b00; n++) begin
         instrValid = 1'b0;
         instr = nextRand();
         @(posedge clk);
         #1;
         r = nextRand();
      end
      instrValid = 1'b1;
      instr = ins;
      if (refExecute(ins, dest, value)) begin
         expAddr.push_back(dest);
         expData.push_back(value);
         lastDest = dest;
      end
      @(posedge clk);
      #1;
   endtask

   // Writebacks checked mid-cycle on the falling edge
   always @(negedge clk) begin : compareResults
      logic [mipsPkg::RegAddrWidth-1:0] addr;
      logic [mipsPkg::DataWidth-1:0]    data;
      if (!reset && wbValid) begin
         if (expAddr.size() == 0) begin
            $display("Writeback to r%0d with no instruction left to retire", wbAddr);
            abortRun();
         end else begin
            addr = expAddr.pop_front();
            data = expData.pop_front();
            compareAddr(wbAddr, addr);
            compareData(wbData, data);
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      int          waitCycles;
      resetRefModel();
      reset = 1'b1;
      instrValid = 1'b0;
      instr = 32'h0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      // Random values into r1..r31 with each ori reading its lui result
      for (int i = 1; i < 32; i++) begin
         r = nextRand();
         issue(encodeI(mipsPkg::OpLui, 5'd0, 5'(i), r[31:16]));
         issue(encodeI(mipsPkg::OpOri, 5'(i), 5'(i), r[15:0]));
      end
      // Fill words 0..15 before any load
      for (int w = 0; w < 16; w++) begin
         issue(encodeI(mipsPkg::OpSw, 5'd0, randReg(), 16'(4 * w)));
      end
      // Every ALU operation
      for (int i = 0; i < 13; i++) begin
         repeat (4) issue(encodeR(functAt(4'(i)), randReg(), randReg(), randReg(), randReg()));
      end
      for (int i = 0; i < 8; i++) begin
         repeat (4) begin
            r = nextRand();
            issue(encodeI(immOpAt(3'(i)), randReg(), randReg(), r[15:0]));
         end
      end
      // r0 written and then read at distance 1 and 2
      gapsAllowed = 1'b0;
      issue(encodeI(mipsPkg::OpAddiu, 5'd7, 5'd0, 16'h1234));
      issue(encodeR(mipsPkg::FnOr, 5'd0, 5'd7, 5'd8, 5'd0));
      issue(encodeR(mipsPkg::FnAddu, 5'd0, 5'd0, 5'd9, 5'd0));
      gapsAllowed = 1'b1;
      // Bytes at each offset read back signed and unsigned
      for (int o = 0; o < 4; o++) begin
         issue(encodeI(mipsPkg::OpSb, 5'd0, randReg(), 16'(16 + o)));
         issue(encodeI(mipsPkg::OpLb, 5'd0, randReg(), 16'(16 + o)));
         issue(encodeI(mipsPkg::OpLbu, 5'd0, randReg(), 16'(16 + o)));
      end
      // Halfwords at both offsets and then the whole word
      for (int o = 0; o < 4; o += 2) begin
         issue(encodeI(mipsPkg::OpSh, 5'd0, randReg(), 16'(20 + o)));
         issue(encodeI(mipsPkg::OpLh, 5'd0, randReg(), 16'(20 + o)));
         issue(encodeI(mipsPkg::OpLhu, 5'd0, randReg(), 16'(20 + o)));
      end
      issue(encodeI(mipsPkg::OpLw, 5'd0, 5'd4, 16'h0014));
      // Load used by the very next instruction
      gapsAllowed = 1'b0;
      issue(encodeI(mipsPkg::OpLw, 5'd0, 5'd5, 16'h0008));
      issue(encodeR(mipsPkg::FnAddu, 5'd5, 5'd5, 5'd6, 5'd0));
      gapsAllowed = 1'b1;
      for (int n = 0; n < 600; n++) begin
         issue(randomInstr());
      end
      instrValid = 1'b0;
      instr = 32'h0;
      // Bounded drain of outstanding writebacks
      waitCycles = 0;
      while (expAddr.size() != 0 && waitCycles < 50) begin
         @(posedge clk);
         waitCycles++;
      end
      // Extra cycles to catch a stray writeback
      repeat (4) @(posedge clk);
      if (expAddr.size() != 0) begin
         $display("Timed out with %0d writebacks still missing", expAddr.size());
         abortRun();
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

//--- common/mipsPkg.sv
package mipsPkg;

   // Datapath sizes
   localparam int DataWidth = 32;
   localparam int RegAddrWidth = 5;
   localparam int NumRegs = 32;
   localparam int DataMemWords = 256;
   localparam int DataMemAddrWidth = 8;

   // Primary opcodes, instr[31:26]
   localparam logic [5:0] OpRType = 6'h00;
   localparam logic [5:0] OpAddi  = 6'h08;
   localparam logic [5:0] OpAddiu = 6'h09;
   localparam logic [5:0] OpSlti  = 6'h0a;
   localparam logic [5:0] OpSltiu = 6'h0b;
   localparam logic [5:0] OpAndi  = 6'h0c;
   localparam logic [5:0] OpOri   = 6'h0d;
   localparam logic [5:0] OpXori  = 6'h0e;
   localparam logic [5:0] OpLui   = 6'h0f;
   localparam logic [5:0] OpLb    = 6'h20;
   localparam logic [5:0] OpLh    = 6'h21;
   localparam logic [5:0] OpLw    = 6'h23;
   localparam logic [5:0] OpLbu   = 6'h24;
   localparam logic [5:0] OpLhu   = 6'h25;
   localparam logic [5:0] OpSb    = 6'h28;
   localparam logic [5:0] OpSh    = 6'h29;
   localparam logic [5:0] OpSw    = 6'h2b;

   // R-type funct codes, instr[5:0]
   localparam logic [5:0] FnSll  = 6'h00;
   localparam logic [5:0] FnSrl  = 6'h02;
   localparam logic [5:0] FnSra  = 6'h03;
   localparam logic [5:0] FnAdd  = 6'h20;
   localparam logic [5:0] FnAddu = 6'h21;
   localparam logic [5:0] FnSub  = 6'h22;
   localparam logic [5:0] FnSubu = 6'h23;
   localparam logic [5:0] FnAnd  = 6'h24;
   localparam logic [5:0] FnOr   = 6'h25;
   localparam logic [5:0] FnXor  = 6'h26;
   localparam logic [5:0] FnNor  = 6'h27;
   localparam logic [5:0] FnSlt  = 6'h2a;
   localparam logic [5:0] FnSltu = 6'h2b;

   typedef enum logic [3:0] {
      AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor,
      AluSlt, AluSltu, AluSll, AluSrl, AluSra, AluLui
   } aluOp_t;

   typedef enum logic [1:0] {
      MemByte, MemHalf, MemWord
   } memSize_t;

   // Decode to execute
   typedef struct packed {
      aluOp_t                  aluOp;
      logic                    srcBImm;
      logic                    shiftShamt;
      logic [DataWidth-1:0]    imm;
      logic [4:0]              shamt;
      logic [DataWidth-1:0]    rd1;
      logic [DataWidth-1:0]    rd2;
      logic [RegAddrWidth-1:0] rs;
      logic [RegAddrWidth-1:0] rt;
      logic [RegAddrWidth-1:0] wa;
      logic                    regWrite;
      logic                    isLoad;
      logic                    isStore;
      memSize_t                memSize;
      logic                    loadUnsigned;
   } execPayload_t;

   // Execute to memory/writeback
   typedef struct packed {
      logic [DataWidth-1:0]    result;
      logic [RegAddrWidth-1:0] wa;
      logic                    regWrite;
      logic                    isLoad;
      memSize_t                memSize;
      logic                    loadUnsigned;
      logic [1:0]              byteOffset;
   } memPayload_t;

endpackage

//--- execute/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
   input  logic                                 execValid,
   input  mipsPkg::execPayload_t                exec,
   input  logic                                 memValid,
   input  logic [mipsPkg::RegAddrWidth-1:0]     memWa,
   input  logic                                 memRegWrite,
   input  logic [mipsPkg::DataWidth-1:0]        memResult,
   output logic                                 memNextValid,
   output mipsPkg::memPayload_t                 memNext,
   output logic                                 storeEn,
   output logic [mipsPkg::DataMemAddrWidth-1:0] storeAddr,
   output logic [mipsPkg::DataWidth-1:0]        storeData,
   output mipsPkg::memSize_t                    storeSize,
   output logic [mipsPkg::DataMemAddrWidth-1:0] loadAddr
);

   logic                          fwdA;
   logic                          fwdB;
   logic [mipsPkg::DataWidth-1:0] rd1Fwd;
   logic [mipsPkg::DataWidth-1:0] rd2Fwd;
   logic [mipsPkg::DataWidth-1:0] aluA;
   logic [mipsPkg::DataWidth-1:0] aluB;
   logic [mipsPkg::DataWidth-1:0] aluOut;

   // Memory to execute forwarding, memResult already holds load data
   assign fwdA = memValid && memRegWrite && memWa != '0 && memWa == exec.rs;
   assign fwdB = memValid && memRegWrite && memWa != '0 && memWa == exec.rt;
   assign rd1Fwd = fwdA ? memResult : exec.rd1;
   assign rd2Fwd = fwdB ? memResult : exec.rd2;

   // Shifts take the amount on A and the value on B
   assign aluA = exec.shiftShamt ? mipsPkg::DataWidth'(exec.shamt) : rd1Fwd;
   assign aluB = exec.srcBImm ? exec.imm : rd2Fwd;

   always_comb begin
      case (exec.aluOp)
         mipsPkg::AluAdd:  aluOut = aluA + aluB;
         mipsPkg::AluSub:  aluOut = aluA - aluB;
         mipsPkg::AluAnd:  aluOut = aluA & aluB;
         mipsPkg::AluOr:   aluOut = aluA | aluB;
         mipsPkg::AluXor:  aluOut = aluA ^ aluB;
         mipsPkg::AluNor:  aluOut = ~(aluA | aluB);
         mipsPkg::AluSlt:  aluOut = mipsPkg::DataWidth'($signed(aluA) < $signed(aluB));
         mipsPkg::AluSltu: aluOut = mipsPkg::DataWidth'(aluA < aluB);
         mipsPkg::AluSll:  aluOut = aluB << aluA[4:0];
         mipsPkg::AluSrl:  aluOut = aluB >> aluA[4:0];
         mipsPkg::AluSra:  aluOut = $signed(aluB) >>> aluA[4:0];
         mipsPkg::AluLui:  aluOut = aluB << 16;
         default:          aluOut = '0;
      endcase
   end

   // Payload for memory/writeback
   assign memNextValid = execValid;
   always_comb begin
      memNext.result = aluOut;
      memNext.wa = exec.wa;
      memNext.regWrite = exec.regWrite;
      memNext.isLoad = exec.isLoad;
      memNext.memSize = exec.memSize;
      memNext.loadUnsigned = exec.loadUnsigned;
      memNext.byteOffset = aluOut[1:0];
   end

   // Word index into data memory, upper address bits ignored
   assign storeAddr = aluOut[mipsPkg::DataMemAddrWidth+1:2];
   assign loadAddr = aluOut[mipsPkg::DataMemAddrWidth+1:2];
   assign storeEn = execValid && exec.isStore;
   assign storeData = rd2Fwd;
   assign storeSize = exec.memSize;

endmodule

//--- memory/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
   input  logic                                 clk,
   input  logic                                 storeEn,
   input  logic [mipsPkg::DataMemAddrWidth-1:0] storeAddr,
   input  logic [mipsPkg::DataWidth-1:0]        storeData,
   input  mipsPkg::memSize_t                    storeSize,
   input  logic [1:0]                           byteOffset,
   input  logic [mipsPkg::DataMemAddrWidth-1:0] loadAddr,
   output logic [mipsPkg::DataWidth-1:0]        readWord
);

   logic [mipsPkg::DataWidth-1:0] mem [mipsPkg::DataMemWords];
   logic [mipsPkg::DataWidth-1:0] laneData;
   logic [3:0]                    laneEn;

   // Replicate into every lane, enables pick the one that lands
   always_comb begin
      case (storeSize)
         mipsPkg::MemByte: begin
            laneData = {4{storeData[7:0]}};
            laneEn = 4'b0001 << byteOffset;
         end
         mipsPkg::MemHalf: begin
            laneData = {2{storeData[15:0]}};
            // Halfword placed by offset bit 1 only
            laneEn = byteOffset[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            laneData = storeData;
            laneEn = 4'b1111;
         end
      endcase
   end

   // Byte-lane write, read word registered for the memory stage
   always_ff @(posedge clk) begin
      if (storeEn) begin
         for (int b = 0; b < 4; b++) begin
            if (laneEn[b]) begin
               mem[storeAddr][8*b +: 8] <= laneData[8*b +: 8];
            end
         end
      end
      readWord <= mem[loadAddr];
   end

endmodule

//--- project.f
+incdir+bench
common/mipsPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/stageReg.sv
execute/executeUnit.sv
memory/dataMemory.sv
verilog/writeBack.sv
verilog/mipsCore.sv
bench/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module mipsCoreTb -o mipsSim &&
./obj_dir/mipsSim || exit 1

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
   input  logic                                instrValid,
   input  logic [31:0]                         instr,
   input  logic [mipsPkg::DataWidth-1:0]       rd1,
   input  logic [mipsPkg::DataWidth-1:0]       rd2,
   output logic [mipsPkg::RegAddrWidth-1:0]    rs,
   output logic [mipsPkg::RegAddrWidth-1:0]    rt,
   output logic                                decodedValid,
   output mipsPkg::execPayload_t               decoded
);

   logic [5:0]                      opcode;
   logic [5:0]                      funct;
   logic [mipsPkg::RegAddrWidth-1:0] rd;
   logic [15:0]                     imm16;
   logic                            known;
   logic                            signExt;

   // Instruction fields
   assign opcode = instr[31:26];
   assign rs = instr[25:21];
   assign rt = instr[20:16];
   assign rd = instr[15:11];
   assign funct = instr[5:0];
   assign imm16 = instr[15:0];

   // Unknown encodings drop out as bubbles
   assign decodedValid = instrValid && known;

   always_comb begin
      known = 1'b1;
      signExt = 1'b1;
      decoded = '0;
      decoded.shamt = instr[10:6];
      decoded.rd1 = rd1;
      decoded.rd2 = rd2;
      decoded.rs = rs;
      decoded.rt = rt;
      // I-type default: write rt, B from immediate
      decoded.wa = rt;
      decoded.regWrite = 1'b1;
      decoded.srcBImm = 1'b1;
      decoded.aluOp = mipsPkg::AluAdd;
      decoded.memSize = mipsPkg::MemWord;
      case (opcode)
         mipsPkg::OpRType: begin
            decoded.wa = rd;
            decoded.srcBImm = 1'b0;
            case (funct)
               mipsPkg::FnSll: begin
                  decoded.aluOp = mipsPkg::AluSll;
                  decoded.shiftShamt = 1'b1;
               end
               mipsPkg::FnSrl: begin
                  decoded.aluOp = mipsPkg::AluSrl;
                  decoded.shiftShamt = 1'b1;
               end
               mipsPkg::FnSra: begin
                  decoded.aluOp = mipsPkg::AluSra;
                  decoded.shiftShamt = 1'b1;
               end
               // No overflow traps, so add/sub match their unsigned forms
               mipsPkg::FnAdd, mipsPkg::FnAddu: decoded.aluOp = mipsPkg::AluAdd;
               mipsPkg::FnSub, mipsPkg::FnSubu: decoded.aluOp = mipsPkg::AluSub;
               mipsPkg::FnAnd:  decoded.aluOp = mipsPkg::AluAnd;
               mipsPkg::FnOr:   decoded.aluOp = mipsPkg::AluOr;
               mipsPkg::FnXor:  decoded.aluOp = mipsPkg::AluXor;
               mipsPkg::FnNor:  decoded.aluOp = mipsPkg::AluNor;
               mipsPkg::FnSlt:  decoded.aluOp = mipsPkg::AluSlt;
               mipsPkg::FnSltu: decoded.aluOp = mipsPkg::AluSltu;
               default:         known = 1'b0;
            endcase
         end
         mipsPkg::OpAddi, mipsPkg::OpAddiu: decoded.aluOp = mipsPkg::AluAdd;
         mipsPkg::OpSlti:  decoded.aluOp = mipsPkg::AluSlt;
         mipsPkg::OpSltiu: decoded.aluOp = mipsPkg::AluSltu;
         // Logical immediates are zero extended
         mipsPkg::OpAndi: begin
            decoded.aluOp = mipsPkg::AluAnd;
            signExt = 1'b0;
         end
         mipsPkg::OpOri: begin
            decoded.aluOp = mipsPkg::AluOr;
            signExt = 1'b0;
         end
         mipsPkg::OpXori: begin
            decoded.aluOp = mipsPkg::AluXor;
            signExt = 1'b0;
         end
         mipsPkg::OpLui: begin
            decoded.aluOp = mipsPkg::AluLui;
            signExt = 1'b0;
         end
         // Loads, address is rs + simm
         mipsPkg::OpLb, mipsPkg::OpLbu: begin
            decoded.isLoad = 1'b1;
            decoded.memSize = mipsPkg::MemByte;
            decoded.loadUnsigned = (opcode == mipsPkg::OpLbu);
         end
         mipsPkg::OpLh, mipsPkg::OpLhu: begin
            decoded.isLoad = 1'b1;
            decoded.memSize = mipsPkg::MemHalf;
            decoded.loadUnsigned = (opcode == mipsPkg::OpLhu);
         end
         mipsPkg::OpLw: decoded.isLoad = 1'b1;
         // Stores write memory only
         mipsPkg::OpSb, mipsPkg::OpSh, mipsPkg::OpSw: begin
            decoded.isStore = 1'b1;
            decoded.regWrite = 1'b0;
            if (opcode == mipsPkg::OpSb) begin
               decoded.memSize = mipsPkg::MemByte;
            end else if (opcode == mipsPkg::OpSh) begin
               decoded.memSize = mipsPkg::MemHalf;
            end
         end
         default: known = 1'b0;
      endcase
      decoded.imm = signExt ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};
   end

endmodule

//--- verilog/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             instrValid,
   input  logic [31:0]                      instr,
   output logic                             wbValid,
   output logic [mipsPkg::RegAddrWidth-1:0] wbAddr,
   output logic [mipsPkg::DataWidth-1:0]    wbData
);

   // Decode side
   logic [mipsPkg::RegAddrWidth-1:0] rs;
   logic [mipsPkg::RegAddrWidth-1:0] rt;
   logic [mipsPkg::DataWidth-1:0]    rd1;
   logic [mipsPkg::DataWidth-1:0]    rd2;
   logic                             decodedValid;
   mipsPkg::execPayload_t            decoded;

   // Execute stage
   logic                                 execValid;
   mipsPkg::execPayload_t                execData;
   logic                                 memNextValid;
   mipsPkg::memPayload_t                 memNext;
   logic                                 storeEn;
   logic [mipsPkg::DataMemAddrWidth-1:0] storeAddr;
   logic [mipsPkg::DataWidth-1:0]        storeData;
   mipsPkg::memSize_t                    storeSize;
   logic [mipsPkg::DataMemAddrWidth-1:0] loadAddr;

   // Memory/writeback stage
   logic                          memValid;
   mipsPkg::memPayload_t          memData;
   logic [mipsPkg::DataWidth-1:0] readWord;

   instrDecoder decoder (
      .instrValid   (instrValid),
      .instr        (instr),
      .rd1          (rd1),
      .rd2          (rd2),
      .rs           (rs),
      .rt           (rt),
      .decodedValid (decodedValid),
      .decoded      (decoded)
   );

   // Written from the writeback port
   regFile regs (
      .clk   (clk),
      .reset (reset),
      .ra1   (rs),
      .ra2   (rt),
      .wa    (wbAddr),
      .we    (wbValid),
      .wd    (wbData),
      .rd1   (rd1),
      .rd2   (rd2)
   );

   stageReg #(.payload_t(mipsPkg::execPayload_t)) execStage (
      .clk      (clk),
      .reset    (reset),
      .inValid  (decodedValid),
      .inData   (decoded),
      .outValid (execValid),
      .outData  (execData)
   );

   // Forwarding taps the final writeback value
   executeUnit execute (
      .execValid    (execValid),
      .exec         (execData),
      .memValid     (memValid),
      .memWa        (memData.wa),
      .memRegWrite  (memData.regWrite),
      .memResult    (wbData),
      .memNextValid (memNextValid),
      .memNext      (memNext),
      .storeEn      (storeEn),
      .storeAddr    (storeAddr),
      .storeData    (storeData),
      .storeSize    (storeSize),
      .loadAddr     (loadAddr)
   );

   dataMemory dmem (
      .clk        (clk),
      .storeEn    (storeEn),
      .storeAddr  (storeAddr),
      .storeData  (storeData),
      .storeSize  (storeSize),
      .byteOffset (memNext.byteOffset),
      .loadAddr   (loadAddr),
      .readWord   (readWord)
   );

   stageReg #(.payload_t(mipsPkg::memPayload_t)) memStage (
      .clk      (clk),
      .reset    (reset),
      .inValid  (memNextValid),
      .inData   (memNext),
      .outValid (memValid),
      .outData  (memData)
   );

   writeBack wb (
      .memValid (memValid),
      .mem      (memData),
      .readWord (readWord),
      .wbValid  (wbValid),
      .wbAddr   (wbAddr),
      .wbData   (wbData)
   );

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [mipsPkg::RegAddrWidth-1:0] ra1,
   input  logic [mipsPkg::RegAddrWidth-1:0] ra2,
   input  logic [mipsPkg::RegAddrWidth-1:0] wa,
   input  logic                             we,
   input  logic [mipsPkg::DataWidth-1:0]    wd,
   output logic [mipsPkg::DataWidth-1:0]    rd1,
   output logic [mipsPkg::DataWidth-1:0]    rd2
);

   logic [mipsPkg::DataWidth-1:0] regs [mipsPkg::NumRegs];

   // r0 never written
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < mipsPkg::NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wa != '0) begin
         regs[wa] <= wd;
      end
   end

   // Writeback bypass, the write lands at the same edge decode moves on
   assign rd1 = (ra1 == '0) ? '0 : (we && ra1 == wa) ? wd : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : (we && ra2 == wa) ? wd : regs[ra2];

endmodule

//--- verilog/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     inValid,
   input  payload_t inData,
   output logic     outValid,
   output payload_t outData
);

   // Valid bit, cleared so no stray write leaves reset
   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
      end else begin
         outValid <= inValid;
      end
   end

   // Payload loads every cycle, stages never hold
   always_ff @(posedge clk) begin
      outData <= inData;
   end

endmodule

//--- verilog/writeBack.sv
`timescale 1ns/1ps

module writeBack (
   input  logic                             memValid,
   input  mipsPkg::memPayload_t             mem,
   input  logic [mipsPkg::DataWidth-1:0]    readWord,
   output logic                             wbValid,
   output logic [mipsPkg::RegAddrWidth-1:0] wbAddr,
   output logic [mipsPkg::DataWidth-1:0]    wbData
);

   logic [7:0]                    loadByte;
   logic [15:0]                   loadHalf;
   logic [mipsPkg::DataWidth-1:0] loadData;

   // Pick the addressed byte or halfword out of the word
   assign loadByte = readWord[8*mem.byteOffset +: 8];
   assign loadHalf = mem.byteOffset[1] ? readWord[31:16] : readWord[15:0];

   always_comb begin
      case (mem.memSize)
         mipsPkg::MemByte: begin
            loadData = mem.loadUnsigned ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
         end
         mipsPkg::MemHalf: begin
            loadData = mem.loadUnsigned ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
         end
         default: loadData = readWord;
      endcase
   end

   // r0 writes still show up here
   assign wbValid = memValid && mem.regWrite;
   assign wbAddr = mem.wa;
   assign wbData = mem.isLoad ? loadData : mem.result;

endmodule
